// ==== filelist.f ====
+incdir+common
+incdir+verif
common/isa_pkg.sv
common/core_pkg.sv
verilog/reg_file.sv
core/alu.sv
core/decoder.sv
core/sequencer.sv
core/cpu_top.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the cpu testbench with verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cpu_tb -f filelist.f \
    && ./obj_dir/Vcpu_tb > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "All tests passed" sim.log \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

// ==== verif/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// instruction encoders.
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                      input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                      input int rd, input int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'd2, imm[4:0], 7'h23};   // sw only.
endfunction

function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                      input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_u(input int imm, input int rd, input int op);
    return {imm[19:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
endfunction

////////////////////////////////////////////////////////////////////////////
// instruction-set model.
////////////////////////////////////////////////////////////////////////////

// untouched memory reads back a pattern of its address.
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h6b3c_91d5;
endfunction

function automatic logic [31:0] read_ref(input logic [31:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
endfunction

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'd0, $signed(a) < $signed(b)};
        3'd3: return {31'd0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

// runs the program in ref_mem, fills exp_stores and the end state.
task automatic run_model();
    logic [31:0] x [0:31];
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] val;
    logic [2:0] f3;
    logic we;
    int i;
    int steps;
    for (i = 0; i < 32; i++) x[i] = '0;
    pc = `RESET_PC;
    exp_stores.delete();
    exp_halt = 1'b0;
    exp_error = 1'b0;
    exp_requests = 0;
    for (steps = 0; steps < MAX_WORDS && !exp_halt && !exp_error; steps++) begin
        if (pc[1:0] != 2'b00) begin
            exp_error = 1'b1;   // misaligned fetch.
        end else begin
            exp_requests++;
            ins = read_ref(pc);
            f3 = ins[14:12];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            we = 1'b1;
            nxt = pc + 32'd4;
            case (ins[6:0])
                7'h33: val = alu_model(f3, ins[30], a, b);
                7'h13: val = alu_model(f3, f3 == 3'd5 && ins[30], a, imm_i);
                7'h37: val = {ins[31:12], 12'h000};
                7'h17: val = pc + {ins[31:12], 12'h000};
                7'h6f: begin
                    val = pc + 32'd4;
                    nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'h67: begin
                    val = pc + 32'd4;
                    nxt = (a + imm_i) & ~32'd1;
                end
                7'h63: begin
                    we = 1'b0;
                    if (branch_model(f3, a, b))
                        nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                7'h03: begin
                    addr = a + imm_i;
                    if (addr[1:0] != 2'b00) begin
                        exp_error = 1'b1;
                    end else begin
                        exp_requests++;
                        val = read_ref(addr);
                    end
                end
                7'h23: begin
                    we = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (addr[1:0] != 2'b00) begin
                        exp_error = 1'b1;
                    end else begin
                        exp_requests++;
                        ref_mem[addr] = b;
                        exp_stores.push_back({addr, b});
                    end
                end
                7'h0b: begin
                    we = 1'b0;
                    if (f3 == 3'd2) exp_halt = 1'b1;
                    else exp_error = 1'b1;
                end
                default: begin
                    we = 1'b0;
                    exp_error = 1'b1;   // illegal opcode.
                end
            endcase
            if (we && !exp_error && ins[11:7] != 5'd0) x[ins[11:7]] = val;
            pc = nxt;
        end
    end
endtask

`endif

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_TESTS = 7;
    localparam int MAX_WORDS = 100;   // longest program.
    localparam int DATA_BASE = 'h100;
    localparam int STORE_BASE = 'h600;
    localparam int WATCHDOG_NS = N_TESTS * (MAX_WORDS * 20 + RESET_CYCLES + 100) * CLK_PERIOD;

    logic clk;
    logic nreset;
    logic mem_ready;
    core_pkg::word_t mem_rdata;
    core_pkg::word_t mem_address;
    core_pkg::word_t mem_wdata;
    logic mem_we;
    logic mem_req;
    logic hlt;
    logic error;

    int seed = 32'ha29758b2;
    logic [31:0] mem [logic [31:0]];
    logic [31:0] ref_mem [logic [31:0]];
    logic [63:0] exp_stores[$];
    logic [63:0] act_stores[$];
    logic [31:0] req_addr[$];
    logic req_we[$];
    int exp_requests;
    logic exp_halt;
    logic exp_error;
    logic [31:0] gen_pc;
    int n_words;
    int busy;
    int wait_cnt;
    int test_errors;
    int tests_failed = 0;

    `include "ref_model.svh"

    cpu_top dut (
        .clk(clk), .nreset(nreset),
        .mem_address(mem_address), .mem_wdata(mem_wdata),
        .mem_we(mem_we), .mem_req(mem_req),
        .mem_rdata(mem_rdata), .mem_ready(mem_ready),
        .hlt(hlt), .error(error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] read_mem(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : fill_word(addr);
    endfunction

    task automatic fail_value(input string name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
        $display("Fail %s %s: expected %h actual %h", name, what, expected, actual);
        test_errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory bus responder.
    ////////////////////////////////////////////////////////////////////////////

    task automatic serve_bus();
        if (mem_ready) begin
            mem_ready = 1'b0;   // transfer took the last rising edge.
            busy = 0;
        end else if (mem_req) begin
            if (busy == 0) begin
                busy = 1;
                wait_cnt = rnd(4);
            end
            if (wait_cnt > 0) begin
                wait_cnt--;
            end else begin
                req_addr.push_back(mem_address);
                req_we.push_back(mem_we);
                if (mem_we) begin
                    mem[mem_address] = mem_wdata;
                    act_stores.push_back({mem_address, mem_wdata});
                end else begin
                    mem_rdata = read_mem(mem_address);
                end
                mem_ready = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // program generator.
    ////////////////////////////////////////////////////////////////////////////

    task automatic emit(input logic [31:0] word);
        mem[gen_pc] = word;
        gen_pc += 32'd4;
        n_words++;
    endtask

    task automatic emit_alu();
        int f3;
        int f7;
        int imm;
        f3 = rnd(8);
        f7 = ((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 'h20 : 0;
        imm = (f3 == 1) ? rnd(32) : (f3 == 5) ? ((f7 << 5) | rnd(32)) : rnd(4096);
        case (rnd(3))
            0: emit(enc_r(f7, rnd(8), rnd(8), f3, 1 + rnd(7)));
            1: emit(enc_i(imm, rnd(8), f3, 1 + rnd(7), 'h13));
            default: emit(enc_u(rnd(1 << 20), 1 + rnd(7), rnd(2) == 1 ? 'h37 : 'h17));
        endcase
    endtask

    // mix 0 is alu only, 1 adds lw, 2 adds control flow.
    task automatic emit_body(input int mix);
        int choice;
        int f3;
        int rb;
        choice = (mix == 0) ? 0 : (mix == 1) ? rnd(2) : rnd(4);
        if (mix == 2 && choice != 0) choice++;
        f3 = rnd(6);
        if (f3 >= 2) f3 += 2;   // no funct3 2 or 3 for branches.
        rb = 1 + rnd(7);
        case (choice)
            0: emit_alu();
            1: emit(enc_i(DATA_BASE + 4 * rnd(64), 0, 2, 1 + rnd(7), 'h03));
            2: begin
                emit(enc_b(8, rnd(8), rnd(8), f3));
                emit_alu();   // skipped when taken.
            end
            3: begin
                emit(enc_j(8, 1 + rnd(7)));
                emit_alu();
            end
            default: begin
                emit(enc_u(0, rb, 'h17));
                emit(enc_i(12, rb, 0, 1 + rnd(7), 'h67));
                emit_alu();
            end
        endcase
    endtask

    // trap 1 is an illegal opcode, trap 2 a misaligned lw.
    task automatic build_program(input int mix, input int n_body, input int trap);
        int i;
        mem.delete();
        gen_pc = `RESET_PC;
        n_words = 0;
        for (i = 0; i < 64; i++) mem[DATA_BASE + 4 * i] = $random(seed);
        for (i = 1; i < 8; i++) begin
            emit(enc_u(rnd(1 << 20), i, 'h37));
            emit(enc_i(rnd(4096), i, 0, i, 'h13));
        end
        for (i = 0; i < n_body; i++) emit_body(mix);
        if (trap == 1) emit(32'h0000_007f);
        else if (trap == 2) emit(enc_i(DATA_BASE + 2, 0, 2, 1 + rnd(7), 'h03));
        for (i = 1; i < 8; i++) emit(enc_s(STORE_BASE + 4 * i, i, 0));
        emit(enc_i(0, 0, 2, 0, 'h0b));   // halt.
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequencing and checks.
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_reset(input string name);
        @(negedge clk);
        nreset = 1'b0;
        mem_ready = 1'b0;
        busy = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (mem_req === 1'b0 && hlt === 1'b0 && error === 1'b0)
            else fail_value(name, "req/hlt/error in reset", 64'd0, 64'({mem_req, hlt, error}));
        end
        nreset = 1'b1;
    endtask

    task automatic run_test(input string name, input int mix, input int n_body,
                            input int trap);
        int i;
        int cycles;
        int limit;
        test_errors = 0;
        build_program(mix, n_body, trap);
        ref_mem = mem;
        run_model();
        act_stores.delete();
        req_addr.delete();
        req_we.delete();
        apply_reset(name);
        limit = n_words * 20 + 50;
        cycles = 0;
        while (!hlt && !error && cycles < limit) begin
            @(negedge clk);
            serve_bus();
            cycles++;
        end
        assert (cycles < limit)
        else begin
            $display("test %s: no hlt or error within %0d cycles", name, limit);
            test_errors++;
        end
        repeat (20) begin   // any request now would be a stray one.
            @(negedge clk);
            serve_bus();
        end
        assert (req_addr.size() > 0 && req_addr[0] === `RESET_PC && req_we[0] === 1'b0)
        else begin
            $display("test %s: first request was not a read at the reset address", name);
            test_errors++;
        end
        assert (hlt === exp_halt) else fail_value(name, "hlt", 64'(exp_halt), 64'(hlt));
        assert (error === exp_error) else fail_value(name, "error", 64'(exp_error), 64'(error));
        assert (req_addr.size() == exp_requests)
        else fail_value(name, "request count", 64'(exp_requests), 64'(req_addr.size()));
        assert (act_stores.size() == exp_stores.size())
        else fail_value(name, "store count", 64'(exp_stores.size()), 64'(act_stores.size()));
        for (i = 0; i < exp_stores.size() && i < act_stores.size(); i++) begin
            assert (act_stores[i] === exp_stores[i])
            else fail_value(name, "store address/data", exp_stores[i], act_stores[i]);
        end
        if (test_errors != 0) tests_failed++;
        $display("test %-10s %s", name, test_errors == 0 ? "ok" : "FAILED");
    endtask

    initial begin
        nreset = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        busy = 0;
        wait_cnt = 0;
        run_test("reset", 0, 4, 0);
        run_test("alu", 0, 24, 0);
        run_test("loads", 1, 24, 0);
        run_test("control", 2, 24, 0);
        run_test("halt", 0, 8, 0);
        run_test("illegal", 0, 8, 1);
        run_test("misaligned", 0, 8, 2);
        $display("%0d tests, %0d passed, %0d failed", N_TESTS, N_TESTS - tests_failed,
                 tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== core/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_top (
    input wire clk,
    input wire nreset,
    output core_pkg::word_t mem_address,
    output core_pkg::word_t mem_wdata,
    output logic mem_we,
    output logic mem_req,
    input wire core_pkg::word_t mem_rdata,
    input wire mem_ready,
    output logic hlt,
    output logic error
);
    core_pkg::word_t instruction;
    isa_pkg::instr_class_t instr_class;
    isa_pkg::alu_op_t alu_op;
    isa_pkg::branch_cond_t branch_cond;
    logic use_imm;
    core_pkg::word_t imm;
    logic [`REG_ADDR_BITS-1:0] rs1;
    logic [`REG_ADDR_BITS-1:0] rs2;
    logic [`REG_ADDR_BITS-1:0] rd;
    core_pkg::word_t rs1_data;
    core_pkg::word_t rs2_data;
    core_pkg::word_t alu_result;
    logic taken;
    logic rd_we;
    core_pkg::word_t rd_data;

    sequencer u_sequencer (
        .clk(clk), .nreset(nreset),
        .mem_rdata(mem_rdata), .mem_ready(mem_ready),
        .instr_class(instr_class), .imm(imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_result(alu_result), .taken(taken),
        .instruction(instruction),
        .mem_address(mem_address), .mem_wdata(mem_wdata),
        .mem_we(mem_we), .mem_req(mem_req),
        .rd_we(rd_we), .rd_data(rd_data),
        .hlt(hlt), .error(error)
    );

    decoder u_decoder (
        .instruction(instruction), .instr_class(instr_class),
        .alu_op(alu_op), .use_imm(use_imm), .branch_cond(branch_cond),
        .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd)
    );

    alu u_alu (
        .alu_op(alu_op), .use_imm(use_imm), .branch_cond(branch_cond),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .result(alu_result), .taken(taken)
    );

    reg_file u_reg_file (
        .clk(clk), .rs1(rs1), .rs2(rs2),
        .rd_we(rd_we), .rd(rd), .rd_data(rd_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

endmodule

`default_nettype wire

// ==== core/sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module sequencer (
    input wire clk,
    input wire nreset,
    input wire core_pkg::word_t mem_rdata,
    input wire mem_ready,
    input wire isa_pkg::instr_class_t instr_class,
    input wire core_pkg::word_t imm,
    input wire core_pkg::word_t rs1_data,
    input wire core_pkg::word_t rs2_data,
    input wire core_pkg::word_t alu_result,
    input wire taken,
    output core_pkg::word_t instruction,
    output core_pkg::word_t mem_address,
    output core_pkg::word_t mem_wdata,
    output logic mem_we,
    output logic mem_req,
    output logic rd_we,
    output core_pkg::word_t rd_data,
    output logic hlt,
    output logic error
);
    core_pkg::stage_t stage;
    core_pkg::word_t pc;
    core_pkg::word_t pc_plus4;
    core_pkg::word_t jalr_sum;
    core_pkg::word_t next_pc;
    core_pkg::word_t wb_value;
    logic is_mem;
    logic writes_rd;

    assign pc_plus4 = pc + 'd4;
    assign jalr_sum = rs1_data + imm;
    assign is_mem = instr_class inside {isa_pkg::cls_load, isa_pkg::cls_store};
    assign writes_rd = instr_class inside {isa_pkg::cls_alu, isa_pkg::cls_load,
                                           isa_pkg::cls_jal, isa_pkg::cls_jalr,
                                           isa_pkg::cls_lui, isa_pkg::cls_auipc};
    assign rd_we = (stage == core_pkg::stage_writeback) && writes_rd;

    always_comb begin
        case (instr_class)
            isa_pkg::cls_branch: next_pc = taken ? pc + imm : pc_plus4;
            isa_pkg::cls_jal:    next_pc = pc + imm;
            isa_pkg::cls_jalr:   next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
            default:             next_pc = pc_plus4;
        endcase
    end

    // loads overwrite this in the memory stage.
    always_comb begin
        case (instr_class)
            isa_pkg::cls_jal, isa_pkg::cls_jalr: wb_value = pc_plus4;   // link.
            isa_pkg::cls_lui:   wb_value = imm;
            isa_pkg::cls_auipc: wb_value = pc + imm;
            default:            wb_value = alu_result;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage machine and bus handshake.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nreset) begin
            stage <= core_pkg::stage_fetch;
            pc <= `RESET_PC;
            mem_req <= 1'b0;
            mem_we <= 1'b0;
            hlt <= 1'b0;
            error <= 1'b0;
        end else if (!hlt && !error) begin
            case (stage)
                core_pkg::stage_fetch: begin
                    if (!mem_req) begin
                        if (pc[1:0] != 2'b00) begin
                            error <= 1'b1;   // misaligned fetch.
                        end else begin
                            mem_req <= 1'b1;
                            mem_address <= pc;
                        end
                    end else if (mem_ready) begin
                        mem_req <= 1'b0;
                        instruction <= mem_rdata;
                        stage <= core_pkg::stage_decode;
                    end
                end
                core_pkg::stage_decode: begin
                    error <= instr_class == isa_pkg::cls_illegal;
                    hlt <= instr_class == isa_pkg::cls_halt;
                    stage <= core_pkg::stage_execute;
                end
                core_pkg::stage_execute: begin
                    pc <= next_pc;
                    rd_data <= wb_value;
                    if (!is_mem) begin
                        stage <= core_pkg::stage_writeback;
                    end else if (alu_result[1:0] != 2'b00) begin
                        error <= 1'b1;
                    end else begin
                        mem_req <= 1'b1;
                        mem_we <= instr_class == isa_pkg::cls_store;
                        mem_address <= alu_result;
                        mem_wdata <= rs2_data;
                        stage <= core_pkg::stage_memory;
                    end
                end
                core_pkg::stage_memory: begin
                    if (mem_ready) begin
                        mem_req <= 1'b0;
                        mem_we <= 1'b0;
                        rd_data <= mem_rdata;   // ignored for stores.
                        stage <= core_pkg::stage_writeback;
                    end
                end
                default: stage <= core_pkg::stage_fetch;   // writeback.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== core/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module decoder (
    input wire core_pkg::word_t instruction,
    output isa_pkg::instr_class_t instr_class,
    output isa_pkg::alu_op_t alu_op,
    output logic use_imm,
    output isa_pkg::branch_cond_t branch_cond,
    output core_pkg::word_t imm,
    output logic [`REG_ADDR_BITS-1:0] rs1,
    output logic [`REG_ADDR_BITS-1:0] rs2,
    output logic [`REG_ADDR_BITS-1:0] rd
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic reg_ok;
    logic imm_ok;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign rd = instruction[11:7];
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];
    assign branch_cond = isa_pkg::branch_cond_t'(funct3);

    // funct7 only selects sub and sra.
    assign reg_ok = funct7 == 7'h00 || (funct7 == 7'h20 && funct3 inside {3'd0, 3'd5});
    assign imm_ok = !(funct3 inside {3'd1, 3'd5}) || funct7 == 7'h00
                    || (funct3 == 3'd5 && funct7 == 7'h20);

    function automatic isa_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    arith_op = alt ? isa_pkg::alu_sub : isa_pkg::alu_add;
            3'd1:    arith_op = isa_pkg::alu_sll;
            3'd2:    arith_op = isa_pkg::alu_slt;
            3'd3:    arith_op = isa_pkg::alu_sltu;
            3'd4:    arith_op = isa_pkg::alu_xor;
            3'd5:    arith_op = alt ? isa_pkg::alu_sra : isa_pkg::alu_srl;
            3'd6:    arith_op = isa_pkg::alu_or;
            default: arith_op = isa_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        instr_class = isa_pkg::cls_illegal;
        alu_op = isa_pkg::alu_add;
        use_imm = 1'b1;
        imm = {{20{instruction[31]}}, instruction[31:20]};   // I format.
        case (opcode)
            isa_pkg::op_reg: begin
                use_imm = 1'b0;
                alu_op = arith_op(funct3, funct7[5]);
                if (reg_ok) instr_class = isa_pkg::cls_alu;
            end
            isa_pkg::op_imm: begin
                alu_op = arith_op(funct3, funct3 == 3'd5 && funct7[5]);
                if (imm_ok) instr_class = isa_pkg::cls_alu;
            end
            isa_pkg::op_load: begin
                if (funct3 == 3'd2) instr_class = isa_pkg::cls_load;
            end
            isa_pkg::op_store: begin
                imm = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
                if (funct3 == 3'd2) instr_class = isa_pkg::cls_store;
            end
            isa_pkg::op_branch: begin
                use_imm = 1'b0;
                imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
                if (!(funct3 inside {3'd2, 3'd3})) instr_class = isa_pkg::cls_branch;
            end
            isa_pkg::op_jal: begin
                imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
                instr_class = isa_pkg::cls_jal;
            end
            isa_pkg::op_jalr: begin
                if (funct3 == 3'd0) instr_class = isa_pkg::cls_jalr;
            end
            isa_pkg::op_lui: begin
                imm = {instruction[31:12], 12'h000};
                instr_class = isa_pkg::cls_lui;
            end
            isa_pkg::op_auipc: begin
                imm = {instruction[31:12], 12'h000};
                instr_class = isa_pkg::cls_auipc;
            end
            isa_pkg::op_custom: begin
                if (funct3 == 3'd2) instr_class = isa_pkg::cls_halt;
            end
            default: instr_class = isa_pkg::cls_illegal;
        endcase
    end

endmodule

`default_nettype wire

// ==== core/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module alu (
    input wire isa_pkg::alu_op_t alu_op,
    input wire use_imm,
    input wire isa_pkg::branch_cond_t branch_cond,
    input wire core_pkg::word_t rs1_data,
    input wire core_pkg::word_t rs2_data,
    input wire core_pkg::word_t imm,
    output core_pkg::word_t result,
    output logic taken
);
    core_pkg::word_t operand_b;
    logic [4:0] shamt;

    assign operand_b = use_imm ? imm : rs2_data;
    assign shamt = operand_b[4:0];

    always_comb begin
        case (alu_op)
            isa_pkg::alu_add:  result = rs1_data + operand_b;
            isa_pkg::alu_sub:  result = rs1_data - operand_b;
            isa_pkg::alu_sll:  result = rs1_data << shamt;
            isa_pkg::alu_srl:  result = rs1_data >> shamt;
            isa_pkg::alu_sra:  result = $signed(rs1_data) >>> shamt;
            isa_pkg::alu_xor:  result = rs1_data ^ operand_b;
            isa_pkg::alu_or:   result = rs1_data | operand_b;
            isa_pkg::alu_and:  result = rs1_data & operand_b;
            isa_pkg::alu_slt:
                result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(operand_b)};
            isa_pkg::alu_sltu: result = {{(`XLEN-1){1'b0}}, rs1_data < operand_b};
            default:           result = '0;
        endcase
    end

    // branches always compare the two registers.
    always_comb begin
        case (branch_cond)
            isa_pkg::br_eq:  taken = rs1_data == rs2_data;
            isa_pkg::br_ne:  taken = rs1_data != rs2_data;
            isa_pkg::br_lt:  taken = $signed(rs1_data) < $signed(rs2_data);
            isa_pkg::br_ge:  taken = $signed(rs1_data) >= $signed(rs2_data);
            isa_pkg::br_ltu: taken = rs1_data < rs2_data;
            isa_pkg::br_geu: taken = rs1_data >= rs2_data;
            default:         taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module reg_file (
    input wire clk,
    input wire [`REG_ADDR_BITS-1:0] rs1,
    input wire [`REG_ADDR_BITS-1:0] rs2,
    input wire rd_we,
    input wire [`REG_ADDR_BITS-1:0] rd,
    input wire core_pkg::word_t rd_data,
    output core_pkg::word_t rs1_data,
    output core_pkg::word_t rs2_data
);
    core_pkg::word_t regs [0:(1 << `REG_ADDR_BITS)-1];

    // x0 is never written.
    always_ff @(posedge clk) begin
        if (rd_we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 reads as zero.
    always_ff @(posedge clk) begin
        rs1_data <= (rs1 == '0) ? '0 : regs[rs1];
        rs2_data <= (rs2 == '0) ? '0 : regs[rs2];
    end

endmodule

`default_nettype wire

// ==== common/core_pkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        stage_fetch,
        stage_decode,
        stage_execute,
        stage_memory,     // lw and sw only.
        stage_writeback
    } stage_t;

endpackage

`default_nettype wire

// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_custom = 7'b0001011,   // halt lives here.
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        cls_alu, cls_load, cls_store, cls_branch, cls_jal,
        cls_jalr, cls_lui, cls_auipc, cls_halt, cls_illegal
    } instr_class_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_srl, alu_sra,
        alu_xor, alu_or, alu_and, alu_slt, alu_sltu
    } alu_op_t;

    // values are the branch funct3 codes.
    typedef enum logic [2:0] {
        br_eq = 3'd0, br_ne = 3'd1, br_lt = 3'd4,
        br_ge = 3'd5, br_ltu = 3'd6, br_geu = 3'd7
    } branch_cond_t;

endpackage

`default_nettype wire

// ==== common/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// core sizing.
////////////////////////////////////////////////////////////////////////////

`define XLEN 32           // data and address width.
`define REG_ADDR_BITS 5   // 32 registers.

////////////////////////////////////////////////////////////////////////////
// boot.
////////////////////////////////////////////////////////////////////////////

`define RESET_PC 32'h4000_0000

`endif
